// ==== src/trace_pkg.sv ====
/* rv32i retirement tracer shared definitions
   data widths, opcode map, instruction field positions and record classes */

package trace_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] cycle_t;

  // instruction class reported in each trace record
  typedef enum logic [3:0] {
    CLS_LUI      = 4'd0,
    CLS_AUIPC    = 4'd1,
    CLS_JAL      = 4'd2,
    CLS_JALR     = 4'd3,
    CLS_BRANCH   = 4'd4,
    CLS_LOAD     = 4'd5,
    CLS_STORE    = 4'd6,
    CLS_OP_IMM   = 4'd7,
    CLS_OP       = 4'd8,
    CLS_MISC_MEM = 4'd9,
    CLS_SYSTEM   = 4'd10,
    CLS_INVALID  = 4'd11
  } iclass_e;

  //////////////////////////////////////////////////////////////////////
  // rv32i base opcodes
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // lsb of each instruction field
  localparam int FIELD_RD_LSB     = 7;
  localparam int FIELD_FUNCT3_LSB = 12;
  localparam int FIELD_RS1_LSB    = 15;
  localparam int FIELD_RS2_LSB    = 20;

  // output record queue, power of two
  localparam int TRACE_FIFO_DEPTH = 4;

endpackage

// ==== src/instr_decoder.sv ====
/* rv32i instruction classifier
   maps a decode-stage word to its class and register usage */

`timescale 1ns/10ps

module instr_decoder
  import trace_pkg::*;
(
  input  xlen_t    instr,
  output iclass_e  iclass,
  output reg_idx_t rd,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     reads_rs1,
  output logic     reads_rs2,
  output logic     writes_rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rd_field;
  reg_idx_t   rs1_field;
  reg_idx_t   rs2_field;
  logic       use_rd;
  logic       use_rs1;
  logic       use_rs2;

  assign opcode    = instr[6:0];
  assign funct3    = instr[FIELD_FUNCT3_LSB +: 3];
  assign rd_field  = instr[FIELD_RD_LSB +: 5];
  assign rs1_field = instr[FIELD_RS1_LSB +: 5];
  assign rs2_field = instr[FIELD_RS2_LSB +: 5];

  // class and raw register usage per opcode
  always_comb begin
    iclass  = CLS_INVALID;
    use_rd  = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_LUI: begin
        iclass = CLS_LUI;
        use_rd = 1'b1;
      end
      OPC_AUIPC: begin
        iclass = CLS_AUIPC;
        use_rd = 1'b1;
      end
      OPC_JAL: begin
        iclass = CLS_JAL;
        use_rd = 1'b1;
      end
      OPC_JALR: begin
        iclass  = CLS_JALR;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
      end
      OPC_BRANCH: begin
        iclass  = CLS_BRANCH;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_LOAD: begin
        // no lwu/ld in rv32, and funct3 7 is unused
        if (!(funct3 inside {3'd3, 3'd6, 3'd7})) begin
          iclass  = CLS_LOAD;
          use_rd  = 1'b1;
          use_rs1 = 1'b1;
        end
      end
      OPC_STORE: begin
        // sb, sh, sw only
        if (funct3 < 3'd3) begin
          iclass  = CLS_STORE;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        iclass  = CLS_OP_IMM;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
      end
      OPC_OP: begin
        iclass  = CLS_OP;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_MISC_MEM: begin
        iclass = CLS_MISC_MEM;
      end
      OPC_SYSTEM: begin
        iclass  = CLS_SYSTEM;
        // csr ops write rd; only the register forms read rs1
        use_rd  = (funct3 != 3'd0);
        use_rs1 = (funct3 inside {3'd1, 3'd2, 3'd3});
      end
      default: begin
        iclass = CLS_INVALID;
      end
    endcase
  end

  // x0 is never tracked
  assign writes_rd = use_rd  && (rd_field  != '0);
  assign reads_rs1 = use_rs1 && (rs1_field != '0);
  assign reads_rs2 = use_rs2 && (rs2_field != '0);

  assign rd  = writes_rd ? rd_field  : '0;
  assign rs1 = reads_rs1 ? rs1_field : '0;
  assign rs2 = reads_rs2 ? rs2_field : '0;

endmodule

// ==== src/retire_tracker.sv ====
/* virtual execute and writeback slots of the tracer
   follow each captured instruction to retirement and collect its side effects */

`timescale 1ns/10ps

module retire_tracker
  import trace_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // decode stage
  input  logic     id_capture,
  input  xlen_t    pc,
  input  xlen_t    instr,
  input  xlen_t    rs1_value,
  input  xlen_t    rs2_value,
  input  iclass_e  iclass,
  input  reg_idx_t rd,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  logic     reads_rs1,
  input  logic     reads_rs2,
  input  logic     writes_rd,
  // execute stage
  input  logic     ex_valid,
  input  logic     wb_bypass,
  input  logic     ex_reg_we,
  input  reg_idx_t ex_reg_addr,
  input  xlen_t    ex_reg_wdata,
  input  logic     ex_data_req,
  input  logic     ex_data_gnt,
  input  logic     ex_data_we,
  input  xlen_t    ex_data_addr,
  // writeback stage
  input  logic     wb_valid,
  input  logic     wb_reg_we,
  input  reg_idx_t wb_reg_addr,
  input  xlen_t    wb_reg_wdata,
  // retired record
  output logic     rec_push,
  output cycle_t   rec_cycle,
  output xlen_t    rec_pc,
  output xlen_t    rec_instr,
  output iclass_e  rec_iclass,
  output reg_idx_t rec_rd,
  output xlen_t    rec_rd_wdata,
  output reg_idx_t rec_rs1,
  output xlen_t    rec_rs1_value,
  output reg_idx_t rec_rs2,
  output xlen_t    rec_rs2_value,
  output logic     rec_mem_valid,
  output logic     rec_mem_we,
  output xlen_t    rec_mem_addr
);

  cycle_t   cycle_cnt;

  logic     ex_occ, ex_wr, ex_mem_valid, ex_mem_we;
  cycle_t   ex_cycle;
  xlen_t    ex_pc, ex_instr, ex_wdata, ex_rs1_value, ex_rs2_value, ex_mem_addr;
  iclass_e  ex_iclass;
  reg_idx_t ex_rd, ex_rs1, ex_rs2;

  logic     wb_occ, wb_wr, wb_mem_valid, wb_mem_we;
  cycle_t   wb_cycle;
  xlen_t    wb_pc, wb_instr, wb_wdata, wb_rs1_value, wb_rs2_value, wb_mem_addr;
  iclass_e  wb_iclass;
  reg_idx_t wb_rd, wb_rs1, wb_rs2;

  logic     ex_hit, ex_grant, ex_move, wb_hit;
  xlen_t    ex_wdata_nxt;

  //////////////////////////////////////////////////////////////////////
  // stage events of this edge
  //////////////////////////////////////////////////////////////////////

  assign ex_hit   = ex_occ && ex_wr && ex_reg_we && (ex_reg_addr == ex_rd);
  // only the first granted access is kept
  assign ex_grant = ex_occ && !ex_mem_valid && ex_data_req && ex_data_gnt;
  // branches skip writeback through the bypass
  assign ex_move  = ex_occ && (ex_valid || wb_bypass);
  assign wb_hit   = wb_occ && wb_wr && wb_reg_we && (wb_reg_addr == wb_rd);
  assign rec_push = wb_occ && wb_valid;

  assign ex_wdata_nxt = ex_hit ? ex_reg_wdata : ex_wdata;

  // counter and slot occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
      ex_occ    <= 1'b0;
      wb_occ    <= 1'b0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
      ex_occ    <= id_capture || (ex_occ && !ex_move);
      wb_occ    <= ex_move || (wb_occ && !rec_push);
    end
  end

  // execute slot, cycle is the edge count before the capturing edge
  always_ff @(posedge clk) begin
    if (id_capture) begin
      ex_cycle     <= cycle_cnt;
      ex_pc        <= pc;
      ex_instr     <= instr;
      ex_iclass    <= iclass;
      ex_rd        <= rd;
      ex_wr        <= writes_rd;
      ex_wdata     <= '0;
      ex_rs1       <= rs1;
      ex_rs1_value <= reads_rs1 ? rs1_value : '0;
      ex_rs2       <= rs2;
      ex_rs2_value <= reads_rs2 ? rs2_value : '0;
      ex_mem_valid <= 1'b0;
      ex_mem_we    <= 1'b0;
      ex_mem_addr  <= '0;
    end else begin
      ex_wdata <= ex_wdata_nxt;
      if (ex_grant) begin
        ex_mem_valid <= 1'b1;
        ex_mem_we    <= ex_data_we;
        ex_mem_addr  <= ex_data_addr;
      end
    end
  end

  // writeback slot, takes this edge's execute write and access along
  always_ff @(posedge clk) begin
    if (ex_move) begin
      wb_cycle     <= ex_cycle;
      wb_pc        <= ex_pc;
      wb_instr     <= ex_instr;
      wb_iclass    <= ex_iclass;
      wb_rd        <= ex_rd;
      wb_wr        <= ex_wr;
      wb_wdata     <= ex_wdata_nxt;
      wb_rs1       <= ex_rs1;
      wb_rs1_value <= ex_rs1_value;
      wb_rs2       <= ex_rs2;
      wb_rs2_value <= ex_rs2_value;
      wb_mem_valid <= ex_mem_valid || ex_grant;
      wb_mem_we    <= ex_grant ? ex_data_we : ex_mem_we;
      wb_mem_addr  <= ex_grant ? ex_data_addr : ex_mem_addr;
    end else if (wb_hit) begin
      wb_wdata <= wb_reg_wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // record, includes a write-back on the retiring edge
  //////////////////////////////////////////////////////////////////////

  assign rec_cycle     = wb_cycle;
  assign rec_pc        = wb_pc;
  assign rec_instr     = wb_instr;
  assign rec_iclass    = wb_iclass;
  assign rec_rd        = wb_rd;
  assign rec_rd_wdata  = wb_hit ? wb_reg_wdata : wb_wdata;
  assign rec_rs1       = wb_rs1;
  assign rec_rs1_value = wb_rs1_value;
  assign rec_rs2       = wb_rs2;
  assign rec_rs2_value = wb_rs2_value;
  assign rec_mem_valid = wb_mem_valid;
  assign rec_mem_we    = wb_mem_we;
  assign rec_mem_addr  = wb_mem_addr;

  // the core must not decode over a stalled execute slot
  a_capture_slot_free: assert property (@(posedge clk) disable iff (!rst_n)
    (id_capture && ex_occ) |-> (ex_valid || wb_bypass));

  // some earlier capture has to feed every writeback
  a_wb_has_source: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> (wb_occ || ex_occ));

endmodule

// ==== src/trace_fifo.sv ====
/* trace record output queue
   valid/ready handshake, full-queue pushes dropped with a sticky flag */

`timescale 1ns/10ps

module trace_fifo
  import trace_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rec_push,
  input  cycle_t   rec_cycle,
  input  xlen_t    rec_pc,
  input  xlen_t    rec_instr,
  input  iclass_e  rec_iclass,
  input  reg_idx_t rec_rd,
  input  xlen_t    rec_rd_wdata,
  input  reg_idx_t rec_rs1,
  input  xlen_t    rec_rs1_value,
  input  reg_idx_t rec_rs2,
  input  xlen_t    rec_rs2_value,
  input  logic     rec_mem_valid,
  input  logic     rec_mem_we,
  input  xlen_t    rec_mem_addr,
  input  logic     trace_ready,
  output logic     trace_valid,
  output cycle_t   trace_cycle,
  output xlen_t    trace_pc,
  output xlen_t    trace_instr,
  output iclass_e  trace_iclass,
  output reg_idx_t trace_rd,
  output xlen_t    trace_rd_wdata,
  output reg_idx_t trace_rs1,
  output xlen_t    trace_rs1_value,
  output reg_idx_t trace_rs2,
  output xlen_t    trace_rs2_value,
  output logic     trace_mem_valid,
  output logic     trace_mem_we,
  output xlen_t    trace_mem_addr,
  output logic     trace_overflow
);

  cycle_t   q_cycle     [TRACE_FIFO_DEPTH];
  xlen_t    q_pc        [TRACE_FIFO_DEPTH];
  xlen_t    q_instr     [TRACE_FIFO_DEPTH];
  iclass_e  q_iclass    [TRACE_FIFO_DEPTH];
  reg_idx_t q_rd        [TRACE_FIFO_DEPTH];
  xlen_t    q_rd_wdata  [TRACE_FIFO_DEPTH];
  reg_idx_t q_rs1       [TRACE_FIFO_DEPTH];
  xlen_t    q_rs1_value [TRACE_FIFO_DEPTH];
  reg_idx_t q_rs2       [TRACE_FIFO_DEPTH];
  xlen_t    q_rs2_value [TRACE_FIFO_DEPTH];
  logic     q_mem_valid [TRACE_FIFO_DEPTH];
  logic     q_mem_we    [TRACE_FIFO_DEPTH];
  xlen_t    q_mem_addr  [TRACE_FIFO_DEPTH];

  logic [$clog2(TRACE_FIFO_DEPTH)-1:0]   wr_ptr, rd_ptr;
  logic [$clog2(TRACE_FIFO_DEPTH+1)-1:0] count;
  logic full, push_ok, pop;

  assign full        = (int'(count) == TRACE_FIFO_DEPTH);
  assign push_ok     = rec_push && !full;
  assign trace_valid = (count != '0);
  assign pop         = trace_valid && trace_ready;

  // pointers wrap naturally
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      trace_overflow <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (rec_push && full) begin
        trace_overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      q_cycle[wr_ptr]     <= rec_cycle;
      q_pc[wr_ptr]        <= rec_pc;
      q_instr[wr_ptr]     <= rec_instr;
      q_iclass[wr_ptr]    <= rec_iclass;
      q_rd[wr_ptr]        <= rec_rd;
      q_rd_wdata[wr_ptr]  <= rec_rd_wdata;
      q_rs1[wr_ptr]       <= rec_rs1;
      q_rs1_value[wr_ptr] <= rec_rs1_value;
      q_rs2[wr_ptr]       <= rec_rs2;
      q_rs2_value[wr_ptr] <= rec_rs2_value;
      q_mem_valid[wr_ptr] <= rec_mem_valid;
      q_mem_we[wr_ptr]    <= rec_mem_we;
      q_mem_addr[wr_ptr]  <= rec_mem_addr;
    end
  end

  // head entry, never overwritten while waiting since full blocks writes
  assign trace_cycle     = q_cycle[rd_ptr];
  assign trace_pc        = q_pc[rd_ptr];
  assign trace_instr     = q_instr[rd_ptr];
  assign trace_iclass    = q_iclass[rd_ptr];
  assign trace_rd        = q_rd[rd_ptr];
  assign trace_rd_wdata  = q_rd_wdata[rd_ptr];
  assign trace_rs1       = q_rs1[rd_ptr];
  assign trace_rs1_value = q_rs1_value[rd_ptr];
  assign trace_rs2       = q_rs2[rd_ptr];
  assign trace_rs2_value = q_rs2_value[rd_ptr];
  assign trace_mem_valid = q_mem_valid[rd_ptr];
  assign trace_mem_we    = q_mem_we[rd_ptr];
  assign trace_mem_addr  = q_mem_addr[rd_ptr];

  // a waiting record holds until taken
  a_hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_valid && !trace_ready) |=> (trace_valid && $stable({trace_cycle, trace_pc,
      trace_instr, trace_iclass, trace_rd, trace_rd_wdata, trace_rs1, trace_rs1_value,
      trace_rs2, trace_rs2_value, trace_mem_valid, trace_mem_we, trace_mem_addr})));

endmodule

// ==== src/rv_tracer.sv ====
/* rv32i retirement tracer top
   decoder, retire tracker and output queue in a chain */

`timescale 1ns/10ps

module rv_tracer
  import trace_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // core decode stage
  input  logic     id_capture,
  input  xlen_t    pc,
  input  xlen_t    instr,
  input  xlen_t    rs1_value,
  input  xlen_t    rs2_value,
  // core execute stage
  input  logic     ex_valid,
  input  logic     wb_bypass,
  input  logic     ex_reg_we,
  input  reg_idx_t ex_reg_addr,
  input  xlen_t    ex_reg_wdata,
  input  logic     ex_data_req,
  input  logic     ex_data_gnt,
  input  logic     ex_data_we,
  input  xlen_t    ex_data_addr,
  // core writeback stage
  input  logic     wb_valid,
  input  logic     wb_reg_we,
  input  reg_idx_t wb_reg_addr,
  input  xlen_t    wb_reg_wdata,
  // trace output
  input  logic     trace_ready,
  output logic     trace_valid,
  output cycle_t   trace_cycle,
  output xlen_t    trace_pc,
  output xlen_t    trace_instr,
  output iclass_e  trace_iclass,
  output reg_idx_t trace_rd,
  output xlen_t    trace_rd_wdata,
  output reg_idx_t trace_rs1,
  output xlen_t    trace_rs1_value,
  output reg_idx_t trace_rs2,
  output xlen_t    trace_rs2_value,
  output logic     trace_mem_valid,
  output logic     trace_mem_we,
  output xlen_t    trace_mem_addr,
  output logic     trace_overflow
);

  iclass_e  iclass;
  reg_idx_t rd, rs1, rs2;
  logic     reads_rs1, reads_rs2, writes_rd;

  logic     rec_push, rec_mem_valid, rec_mem_we;
  cycle_t   rec_cycle;
  xlen_t    rec_pc, rec_instr, rec_rd_wdata, rec_rs1_value, rec_rs2_value, rec_mem_addr;
  iclass_e  rec_iclass;
  reg_idx_t rec_rd, rec_rs1, rec_rs2;

  instr_decoder decoder_inst (
    .instr     (instr),
    .iclass    (iclass),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .reads_rs1 (reads_rs1),
    .reads_rs2 (reads_rs2),
    .writes_rd (writes_rd)
  );

  retire_tracker tracker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .id_capture    (id_capture),
    .pc            (pc),
    .instr         (instr),
    .rs1_value     (rs1_value),
    .rs2_value     (rs2_value),
    .iclass        (iclass),
    .rd            (rd),
    .rs1           (rs1),
    .rs2           (rs2),
    .reads_rs1     (reads_rs1),
    .reads_rs2     (reads_rs2),
    .writes_rd     (writes_rd),
    .ex_valid      (ex_valid),
    .wb_bypass     (wb_bypass),
    .ex_reg_we     (ex_reg_we),
    .ex_reg_addr   (ex_reg_addr),
    .ex_reg_wdata  (ex_reg_wdata),
    .ex_data_req   (ex_data_req),
    .ex_data_gnt   (ex_data_gnt),
    .ex_data_we    (ex_data_we),
    .ex_data_addr  (ex_data_addr),
    .wb_valid      (wb_valid),
    .wb_reg_we     (wb_reg_we),
    .wb_reg_addr   (wb_reg_addr),
    .wb_reg_wdata  (wb_reg_wdata),
    .rec_push      (rec_push),
    .rec_cycle     (rec_cycle),
    .rec_pc        (rec_pc),
    .rec_instr     (rec_instr),
    .rec_iclass    (rec_iclass),
    .rec_rd        (rec_rd),
    .rec_rd_wdata  (rec_rd_wdata),
    .rec_rs1       (rec_rs1),
    .rec_rs1_value (rec_rs1_value),
    .rec_rs2       (rec_rs2),
    .rec_rs2_value (rec_rs2_value),
    .rec_mem_valid (rec_mem_valid),
    .rec_mem_we    (rec_mem_we),
    .rec_mem_addr  (rec_mem_addr)
  );

  trace_fifo fifo_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .rec_push        (rec_push),
    .rec_cycle       (rec_cycle),
    .rec_pc          (rec_pc),
    .rec_instr       (rec_instr),
    .rec_iclass      (rec_iclass),
    .rec_rd          (rec_rd),
    .rec_rd_wdata    (rec_rd_wdata),
    .rec_rs1         (rec_rs1),
    .rec_rs1_value   (rec_rs1_value),
    .rec_rs2         (rec_rs2),
    .rec_rs2_value   (rec_rs2_value),
    .rec_mem_valid   (rec_mem_valid),
    .rec_mem_we      (rec_mem_we),
    .rec_mem_addr    (rec_mem_addr),
    .trace_ready     (trace_ready),
    .trace_valid     (trace_valid),
    .trace_cycle     (trace_cycle),
    .trace_pc        (trace_pc),
    .trace_instr     (trace_instr),
    .trace_iclass    (trace_iclass),
    .trace_rd        (trace_rd),
    .trace_rd_wdata  (trace_rd_wdata),
    .trace_rs1       (trace_rs1),
    .trace_rs1_value (trace_rs1_value),
    .trace_rs2       (trace_rs2),
    .trace_rs2_value (trace_rs2_value),
    .trace_mem_valid (trace_mem_valid),
    .trace_mem_we    (trace_mem_we),
    .trace_mem_addr  (trace_mem_addr),
    .trace_overflow  (trace_overflow)
  );

endmodule

// ==== dv/tracer_model.svh ====
/* reference model of the retirement tracer
   decode rules, execute and writeback slots, expected record queue */

`ifndef TRACER_MODEL_SVH
`define TRACER_MODEL_SVH

// one trace record as it leaves the queue
typedef struct packed {
  cycle_t     cycle;
  xlen_t      pc;
  xlen_t      instr;
  logic [3:0] iclass;
  reg_idx_t   rd;
  xlen_t      rd_wdata;
  reg_idx_t   rs1;
  xlen_t      rs1_value;
  reg_idx_t   rs2;
  xlen_t      rs2_value;
  logic       mem_valid;
  logic       mem_we;
  xlen_t      mem_addr;
} trace_rec_t;

trace_rec_t exp_q[$];
trace_rec_t ex_slot;
trace_rec_t wb_slot;
bit         ex_busy;
bit         wb_busy;
bit         ovf_exp;
cycle_t     model_cycle;
int         dropped_cnt;

// record fields known at decode time
function automatic trace_rec_t decode_rec(input xlen_t word, input xlen_t pc_v,
    input xlen_t rs1_v, input xlen_t rs2_v, input cycle_t cyc);
  trace_rec_t r;
  logic [2:0] f3;
  logic [3:0] cls;
  bit         wr;
  bit         uses_rs1;
  bit         uses_rs2;
  r  = '0;
  f3 = word[14:12];
  case (word[6:0])
    OPC_LUI:      cls = CLS_LUI;
    OPC_AUIPC:    cls = CLS_AUIPC;
    OPC_JAL:      cls = CLS_JAL;
    OPC_JALR:     cls = CLS_JALR;
    OPC_BRANCH:   cls = CLS_BRANCH;
    OPC_LOAD:     cls = (f3 == 3'd3 || f3 >= 3'd6) ? CLS_INVALID : CLS_LOAD;
    OPC_STORE:    cls = (f3 >= 3'd3) ? CLS_INVALID : CLS_STORE;
    OPC_OP_IMM:   cls = CLS_OP_IMM;
    OPC_OP:       cls = CLS_OP;
    OPC_MISC_MEM: cls = CLS_MISC_MEM;
    OPC_SYSTEM:   cls = CLS_SYSTEM;
    default:      cls = CLS_INVALID;
  endcase
  wr = (cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_LOAD, CLS_OP_IMM, CLS_OP})
       || (cls == CLS_SYSTEM && f3 != 3'd0);
  uses_rs1 = (cls inside {CLS_JALR, CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_OP})
             || (cls == CLS_SYSTEM && f3 >= 3'd1 && f3 <= 3'd3);
  uses_rs2 = cls inside {CLS_BRANCH, CLS_STORE, CLS_OP};
  r.cycle  = cyc;
  r.pc     = pc_v;
  r.instr  = word;
  r.iclass = cls;
  // x0 never counts as a used register
  if (wr && word[11:7] != 5'd0) begin
    r.rd = word[11:7];
  end
  if (uses_rs1 && word[19:15] != 5'd0) begin
    r.rs1       = word[19:15];
    r.rs1_value = rs1_v;
  end
  if (uses_rs2 && word[24:20] != 5'd0) begin
    r.rs2       = word[24:20];
    r.rs2_value = rs2_v;
  end
  return r;
endfunction

// one rising edge, with the core inputs as now driven
task automatic model_edge(input int unsigned queued);
  bit push;
  bit move;
  push = wb_busy && wb_valid;
  move = ex_busy && (ex_valid || wb_bypass);
  if (ex_busy) begin
    if (ex_slot.rd != 5'd0 && ex_reg_we && ex_reg_addr == ex_slot.rd) begin
      ex_slot.rd_wdata = ex_reg_wdata;
    end
    // first grant wins
    if (!ex_slot.mem_valid && ex_data_req && ex_data_gnt) begin
      ex_slot.mem_valid = 1'b1;
      ex_slot.mem_we    = ex_data_we;
      ex_slot.mem_addr  = ex_data_addr;
    end
  end
  if (wb_busy && wb_slot.rd != 5'd0 && wb_reg_we && wb_reg_addr == wb_slot.rd) begin
    wb_slot.rd_wdata = wb_reg_wdata;
  end
  // queue fill as seen before this edge's pop
  if (push) begin
    if (queued >= TRACE_FIFO_DEPTH) begin
      ovf_exp = 1'b1;
      dropped_cnt++;
    end else begin
      exp_q.push_back(wb_slot);
    end
    wb_busy = 1'b0;
  end
  if (move) begin
    wb_slot = ex_slot;
    wb_busy = 1'b1;
    ex_busy = 1'b0;
  end
  if (id_capture) begin
    ex_slot = decode_rec(instr, pc, rs1_value, rs2_value, model_cycle);
    ex_busy = 1'b1;
  end
  model_cycle++;
endtask

`endif

// ==== dv/tb_rv_tracer.sv ====
/* testbench for the retirement tracer
   random core pipeline checked against a reference model of the records */

`timescale 1ns/10ps

module tb_rv_tracer;
  import trace_pkg::*;

  localparam int NUM_TESTS      = 5;
  localparam int INSTR_PER_TEST = 400;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * INSTR_PER_TEST * 12;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     id_capture;
  xlen_t    pc, instr, rs1_value, rs2_value;
  logic     ex_valid, wb_bypass, ex_reg_we;
  reg_idx_t ex_reg_addr;
  xlen_t    ex_reg_wdata;
  logic     ex_data_req, ex_data_gnt, ex_data_we;
  xlen_t    ex_data_addr;
  logic     wb_valid, wb_reg_we;
  reg_idx_t wb_reg_addr;
  xlen_t    wb_reg_wdata;
  logic     trace_ready;
  logic     trace_valid, trace_mem_valid, trace_mem_we, trace_overflow;
  cycle_t   trace_cycle;
  xlen_t    trace_pc, trace_instr, trace_rd_wdata, trace_rs1_value, trace_rs2_value;
  xlen_t    trace_mem_addr;
  iclass_e  trace_iclass;
  reg_idx_t trace_rd, trace_rs1, trace_rs2;

  integer   seed;
  int       errors;
  int       test_errors;
  int       test_records;
  int       total_records;
  int       issued;
  int       timeout_cnt;
  bit       capture_next;
  bit       waiting;
  xlen_t    next_pc;

  `include "tracer_model.svh"

  trace_rec_t held_rec;

  always #10 clk = ~clk;

  rv_tracer rv_tracer_inst (.*);

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic bit chance(input int pct);
    int unsigned r;
    r = $random(seed);
    return (r % 100) < pct;
  endfunction

  // base opcodes plus two unused ones
  function automatic xlen_t random_instr(input int test);
    xlen_t       w;
    int unsigned pick;
    w    = $random(seed);
    pick = $unsigned($random(seed)) % 13;
    case (pick)
      0:       w[6:0] = OPC_LUI;
      1:       w[6:0] = OPC_AUIPC;
      2:       w[6:0] = OPC_JAL;
      3:       w[6:0] = OPC_JALR;
      4:       w[6:0] = OPC_BRANCH;
      5:       w[6:0] = OPC_LOAD;
      6:       w[6:0] = OPC_STORE;
      7:       w[6:0] = OPC_OP_IMM;
      8:       w[6:0] = OPC_OP;
      9:       w[6:0] = OPC_MISC_MEM;
      10:      w[6:0] = OPC_SYSTEM;
      11:      w[6:0] = 7'b1011011;
      default: w[6:0] = 7'b0000000;
    endcase
    // more x0 destinations in the decode test
    if (test == 1 && chance(20)) begin
      w[11:7] = 5'd0;
    end
    return w;
  endfunction

  function automatic string test_name(input int test);
    case (test)
      1:       return "classes and register flags";
      2:       return "operands and rd write-back";
      3:       return "memory access capture";
      4:       return "bypass and back-to-back";
      default: return "ready throttling and overflow";
    endcase
  endfunction

  function automatic trace_rec_t observed_rec();
    trace_rec_t r;
    r.cycle     = trace_cycle;
    r.pc        = trace_pc;
    r.instr     = trace_instr;
    r.iclass    = trace_iclass;
    r.rd        = trace_rd;
    r.rd_wdata  = trace_rd_wdata;
    r.rs1       = trace_rs1;
    r.rs1_value = trace_rs1_value;
    r.rs2       = trace_rs2;
    r.rs2_value = trace_rs2_value;
    r.mem_valid = trace_mem_valid;
    r.mem_we    = trace_mem_we;
    r.mem_addr  = trace_mem_addr;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_field(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_record(input trace_rec_t got, input trace_rec_t exp);
    compare_field("trace_cycle", got.cycle, exp.cycle);
    compare_field("trace_pc", got.pc, exp.pc);
    compare_field("trace_instr", got.instr, exp.instr);
    compare_field("trace_iclass", 32'(got.iclass), 32'(exp.iclass));
    compare_field("trace_rd", 32'(got.rd), 32'(exp.rd));
    compare_field("trace_rd_wdata", got.rd_wdata, exp.rd_wdata);
    compare_field("trace_rs1", 32'(got.rs1), 32'(exp.rs1));
    compare_field("trace_rs1_value", got.rs1_value, exp.rs1_value);
    compare_field("trace_rs2", 32'(got.rs2), 32'(exp.rs2));
    compare_field("trace_rs2_value", got.rs2_value, exp.rs2_value);
    compare_field("trace_mem_valid", 32'(got.mem_valid), 32'(exp.mem_valid));
    compare_field("trace_mem_we", 32'(got.mem_we), 32'(exp.mem_we));
    compare_field("trace_mem_addr", got.mem_addr, exp.mem_addr);
  endtask

  // observe at the falling edge, drive at the next rising edge
  task automatic step_edge(input int test);
    trace_rec_t  got;
    int unsigned queued;
    bit          retire;
    bit          move;
    bit          bypass;
    bit          take;
    @(negedge clk);
    got    = observed_rec();
    queued = exp_q.size();
    compare_field("trace_valid", 32'(trace_valid), 32'(queued != 0));
    compare_field("trace_overflow", 32'(trace_overflow), 32'(ovf_exp));
    if (waiting) begin
      assert (got === held_rec)
      else begin
        $display("trace record changed while it waited for trace_ready");
        test_errors++;
      end
    end
    waiting  = trace_valid && !trace_ready;
    held_rec = got;
    if (trace_valid && trace_ready) begin
      assert (queued != 0)
      else begin
        $display("trace_valid was high with no record left to deliver");
        test_errors++;
      end
      if (queued != 0) begin
        check_record(got, exp_q[0]);
        void'(exp_q.pop_front());
        test_records++;
      end
    end
    model_edge(queued);

    // core pipeline for the next edge, at most two in flight
    retire = wb_busy && chance(test == 4 ? 90 : 60);
    move   = ex_busy && (!wb_busy || retire) && chance(test == 4 ? 90 : 60);
    bypass = move && chance(test == 4 ? 50 : 15);
    take   = (issued < INSTR_PER_TEST) && (!ex_busy || move) && chance(test == 4 ? 90 : 55);
    capture_next = take;
    @(posedge clk);
    wb_valid     <= retire || (!wb_busy && ex_busy && chance(20));
    ex_valid     <= (move && !bypass) || (!ex_busy && chance(20));
    wb_bypass    <= bypass;
    id_capture   <= take;
    instr        <= random_instr(test);
    pc           <= next_pc;
    rs1_value    <= $random(seed);
    rs2_value    <= $random(seed);
    ex_reg_we    <= chance(test == 2 ? 70 : 30);
    ex_reg_addr  <= (ex_busy && chance(60)) ? ex_slot.rd : reg_idx_t'($random(seed));
    ex_reg_wdata <= $random(seed);
    wb_reg_we    <= chance(test == 2 ? 70 : 30);
    wb_reg_addr  <= (wb_busy && chance(60)) ? wb_slot.rd : reg_idx_t'($random(seed));
    wb_reg_wdata <= $random(seed);
    ex_data_req  <= chance(test == 3 ? 70 : 25);
    ex_data_gnt  <= chance(test == 3 ? 40 : 60);
    ex_data_we   <= chance(50);
    ex_data_addr <= $random(seed);
    if (take) begin
      next_pc = next_pc + 32'd4;
      issued++;
    end
    // throttle, then starve the queue in the last test
    if (test == 5 && issued < INSTR_PER_TEST / 2) begin
      trace_ready <= chance(50);
    end else if (test == 5 && issued < INSTR_PER_TEST) begin
      trace_ready <= 1'b0;
    end else begin
      trace_ready <= 1'b1;
    end
  endtask

  task automatic run_test(input int test);
    test_errors  = 0;
    test_records = 0;
    issued       = 0;
    while (issued < INSTR_PER_TEST || capture_next || ex_busy || wb_busy
           || exp_q.size() != 0) begin
      step_edge(test);
    end
    if (test == 5) begin
      assert (ovf_exp && dropped_cnt > 0)
      else begin
        $display("the queue never overflowed while trace_ready was held low");
        test_errors++;
      end
    end
    $display("test %0d %s: %0d records checked, %0d errors", test, test_name(test),
             test_records, test_errors);
    errors        += test_errors;
    total_records += test_records;
  endtask

  initial begin
    timeout_cnt = 0;
    while (timeout_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      timeout_cnt++;
    end
    $display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed          = 32'h7f22;
    errors        = 0;
    total_records = 0;
    capture_next  = 1'b0;
    waiting       = 1'b0;
    next_pc       = 32'h0000_1000;
    ex_busy       = 1'b0;
    wb_busy       = 1'b0;
    ovf_exp       = 1'b0;
    model_cycle   = '0;
    dropped_cnt   = 0;
    rst_n         = 1'b0;
    id_capture    = 1'b0;
    pc            = '0;
    instr         = '0;
    rs1_value     = '0;
    rs2_value     = '0;
    ex_valid      = 1'b0;
    wb_bypass     = 1'b0;
    ex_reg_we     = 1'b0;
    ex_reg_addr   = '0;
    ex_reg_wdata  = '0;
    ex_data_req   = 1'b0;
    ex_data_gnt   = 1'b0;
    ex_data_we    = 1'b0;
    ex_data_addr  = '0;
    wb_valid      = 1'b0;
    wb_reg_we     = 1'b0;
    wb_reg_addr   = '0;
    wb_reg_wdata  = '0;
    trace_ready   = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("summary: %0d tests, %0d records checked, %0d dropped, %0d errors",
             NUM_TESTS, total_records, dropped_cnt, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+dv
src/trace_pkg.sv
src/instr_decoder.sv
src/retire_tracker.sv
src/trace_fifo.sv
src/rv_tracer.sv
dv/tb_rv_tracer.sv

// ==== run.sh ====
#!/bin/sh
# build the tracer testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_tracer -f files.f
./obj_dir/Vtb_rv_tracer | tee sim.log
if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
